/* hdl/csr_arch_pkg.sv */
package csr_arch_pkg;

  //////////////////////////////
  // CSR address map
  //////////////////////////////
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320, // Also base of the mhpmevent range
    CSR_MHPMEVENT3    = 12'h323,
    CSR_MHPMEVENT31   = 12'h33F,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00, // Low halves, index in bits 4:0
    CSR_MINSTRET      = 12'hB02,
    CSR_MHPMCOUNTER3  = 12'hB03,
    CSR_MHPMCOUNTER31 = 12'hB1F,
    CSR_MCYCLEH       = 12'hB80, // High halves
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHPMCOUNTER3H = 12'hB83,
    CSR_CYCLE         = 12'hC00, // User shadows, read only
    CSR_INSTRET       = 12'hC02,
    CSR_HPMCOUNTER3   = 12'hC03,
    CSR_CYCLEH        = 12'hC80,
    CSR_INSTRETH      = 12'hC82,
    CSR_HPMCOUNTER3H  = 12'hC83,
    CSR_MVENDORID     = 12'hF11,
    CSR_MARCHID       = 12'hF12,
    CSR_MIMPID        = 12'hF13,
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////
  // Register layouts
  //////////////////////////////
  typedef struct packed {
    logic [18:0] pad_hi;  // 31:13
    logic [1:0]  mpp;     // 12:11
    logic [2:0]  pad_mid; // 10:8
    logic        mpie;    // 7
    logic [2:0]  pad_lo;  // 6:4
    logic        mie;     // 3
    logic [2:0]  pad_low; // 2:0
  } mstatus_t;

  typedef struct packed {
    logic        irq;  // Interrupt, not exception
    logic [25:0] zero;
    logic [4:0]  code;
  } mcause_t;

  typedef struct packed {
    logic [23:0] addr; // 256-byte aligned base
    logic [5:0]  zero;
    logic [1:0]  mode; // 0 direct, 1 vectored
  } mtvec_t;

  localparam logic [1:0]  PRIV_M            = 2'b11;
  localparam logic [31:0] MSTATUS_RESET_VAL = 32'h0000_1800; // mpp = M, all enables off
  localparam logic [31:0] MTVEC_RESET_VAL   = 32'h0000_0001; // Vectored at address 0
  localparam logic [31:0] IRQ_MASK          = 32'hFFFF_0888; // Fast 31:16, ext, timer, soft
  localparam int          MSTATUS_MIE_BIT   = 3;
  localparam int          MSTATUS_MPIE_BIT  = 7;
  localparam logic [1:0]  RO_ADDR_TOP       = 2'b11; // addr[11:10] of read-only CSRs

endpackage

/* hdl/csr_cfg_pkg.sv */
package csr_cfg_pkg;

  localparam int MHPMCOUNTER_WIDTH = 64;
  localparam int HPM_EXT_EVENTS    = 7;                  // Events supplied by the core
  localparam int NUM_HPM_EVENTS    = HPM_EXT_EVENTS + 1; // Plus the constant cycle event
  localparam int FIRST_HPM_IDX     = 3;                  // First programmable counter

  // Bit positions in the event vector seen by mhpmevent
  typedef enum logic [2:0] {
    HPM_CYCLE        = 3'd0,
    HPM_INSTRET      = 3'd1,
    HPM_LOAD         = 3'd2,
    HPM_STORE        = 3'd3,
    HPM_BRANCH       = 3'd4,
    HPM_BRANCH_TAKEN = 3'd5,
    HPM_COMPRESSED   = 3'd6,
    HPM_LD_STALL     = 3'd7
  } hpm_event_e;

  // Identity words
  localparam logic [31:0] MVENDORID_VAL = 32'h0000_0000; // Non-commercial
  localparam logic [31:0] MARCHID_VAL   = 32'h0000_0014;
  localparam logic [31:0] MISA_VAL      = 32'h4000_1104; // RV32 I, M, C

endpackage

/* hdl/csr_bus_if.sv */
`timescale 1ns/1ns

interface csr_bus_if;

  logic [11:0] raddr; // Read address, zero when no read is active
  logic        we;    // Write strobe from writeback
  logic [11:0] waddr;
  logic [31:0] wdata; // Already resolved for set and clear
  logic [31:0] rdata;
  logic        hit;   // Bank implements raddr

  modport master (
    output raddr, we, waddr, wdata,
    input  rdata, hit
  );

  modport bank (
    input  raddr, we, waddr, wdata,
    output rdata, hit
  );

endinterface

/* hdl/csr_access.sv */
`timescale 1ns/1ns

module csr_access (
  // Execute stage read
  input  logic                  rd_en_i,
  input  logic [11:0]           rd_addr_i,
  input  csr_arch_pkg::csr_op_e rd_op_i,
  // Writeback stage write
  input  logic                  wr_en_i,
  input  csr_arch_pkg::csr_op_e wr_op_i,
  input  logic [11:0]           wr_addr_i,
  input  logic [31:0]           wr_operand_i,
  input  logic [31:0]           wr_old_i,     // Value read in execute
  output logic [31:0]           rdata_o,
  output logic                  illegal_o,
  csr_bus_if.master             mbus,
  csr_bus_if.master             cbus
);

  logic [11:0] raddr_gated;
  logic        any_hit;
  logic        ro_write;
  logic [31:0] wdata_res;

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Idle address keeps the decoders quiet
  assign raddr_gated = rd_en_i ? rd_addr_i : 12'h000;
  assign mbus.raddr  = raddr_gated;
  assign cbus.raddr  = raddr_gated;

  // Banks never overlap, machine bank first
  assign rdata_o = mbus.hit ? mbus.rdata :
                   cbus.hit ? cbus.rdata : 32'h0;

  assign any_hit  = mbus.hit | cbus.hit;
  assign ro_write = (rd_op_i != csr_arch_pkg::CSR_OP_READ) &&
                    (rd_addr_i[11:10] == csr_arch_pkg::RO_ADDR_TOP); // Priv spec 2.1

  assign illegal_o = rd_en_i && (!any_hit || ro_write);

  //////////////////////////////
  // Write side
  //////////////////////////////

  // Read-modify-write against the value read in execute
  always_comb begin
    case (wr_op_i)
      csr_arch_pkg::CSR_OP_WRITE: wdata_res = wr_operand_i;
      csr_arch_pkg::CSR_OP_SET:   wdata_res = wr_operand_i | wr_old_i;
      csr_arch_pkg::CSR_OP_CLEAR: wdata_res = ~wr_operand_i & wr_old_i;
      default:                    wdata_res = wr_operand_i; // Read, no store follows
    endcase
  end

  assign mbus.we    = wr_en_i && (wr_op_i != csr_arch_pkg::CSR_OP_READ);
  assign mbus.waddr = wr_addr_i;
  assign mbus.wdata = wdata_res;

  // Counter bank sees the same write
  assign cbus.we    = wr_en_i && (wr_op_i != csr_arch_pkg::CSR_OP_READ);
  assign cbus.waddr = wr_addr_i;
  assign cbus.wdata = wdata_res;

endmodule

/* hdl/csr_machine_regs.sv */
`timescale 1ns/1ns

module csr_machine_regs (
  input  logic        clk,
  input  logic        rst_n,
  csr_bus_if.bank     bus,
  input  logic [31:0] hart_id_i,
  input  logic [31:0] mip_i,
  // Trap control
  input  logic        trap_save_i,
  input  logic [5:0]  trap_cause_i,  // Bit 5 flags an interrupt
  input  logic [31:0] trap_pc_i,
  input  logic        mret_i,
  // To the core
  output logic [31:0] mie_o,
  output logic [31:0] mepc_o,
  output logic [23:0] mtvec_addr_o,
  output logic [1:0]  mtvec_mode_o,
  output logic        m_irq_enable_o
);

  csr_arch_pkg::mstatus_t mstatus_q, mstatus_n;
  csr_arch_pkg::mcause_t  mcause_q, mcause_n;
  csr_arch_pkg::mtvec_t   mtvec_q;
  logic [31:0]            mie_q;
  logic [31:0]            mscratch_q;
  logic [31:0]            mepc_q, mepc_n;

  logic wr_mstatus, wr_mie, wr_mtvec, wr_mscratch, wr_mepc, wr_mcause;

  // Write address decode
  assign wr_mstatus  = bus.we && (bus.waddr == csr_arch_pkg::CSR_MSTATUS);
  assign wr_mie      = bus.we && (bus.waddr == csr_arch_pkg::CSR_MIE);
  assign wr_mtvec    = bus.we && (bus.waddr == csr_arch_pkg::CSR_MTVEC);
  assign wr_mscratch = bus.we && (bus.waddr == csr_arch_pkg::CSR_MSCRATCH);
  assign wr_mepc     = bus.we && (bus.waddr == csr_arch_pkg::CSR_MEPC);
  assign wr_mcause   = bus.we && (bus.waddr == csr_arch_pkg::CSR_MCAUSE);

  //////////////////////////////
  // Trap registers
  //////////////////////////////
  always_comb begin
    mstatus_n = mstatus_q;
    mepc_n    = mepc_q;
    mcause_n  = mcause_q;
    if (wr_mstatus) begin
      mstatus_n = '{mpp:     csr_arch_pkg::PRIV_M,
                    mpie:    bus.wdata[csr_arch_pkg::MSTATUS_MPIE_BIT],
                    mie:     bus.wdata[csr_arch_pkg::MSTATUS_MIE_BIT],
                    default: '0};
    end
    if (wr_mepc) mepc_n = bus.wdata & ~32'h1;      // Always halfword aligned
    if (wr_mcause) mcause_n = '{irq: bus.wdata[31], zero: '0, code: bus.wdata[4:0]};

    // Trap and mret override the software write
    if (trap_save_i) begin
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;              // Handler starts with interrupts off
      mstatus_n.mpp  = csr_arch_pkg::PRIV_M;
      mepc_n         = trap_pc_i;
      mcause_n       = '{irq: trap_cause_i[5], zero: '0, code: trap_cause_i[4:0]};
    end else if (mret_i) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= csr_arch_pkg::MSTATUS_RESET_VAL;
      mtvec_q    <= csr_arch_pkg::MTVEC_RESET_VAL;
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q <= mstatus_n;
      mepc_q    <= mepc_n;
      mcause_q  <= mcause_n;
      if (wr_mie) mie_q <= bus.wdata & csr_arch_pkg::IRQ_MASK; // Only real IRQ lines stick
      if (wr_mtvec) begin
        mtvec_q <= '{addr: bus.wdata[31:8], zero: '0, mode: {1'b0, bus.wdata[0]}};
      end
      if (wr_mscratch) mscratch_q <= bus.wdata;
    end
  end

  //////////////////////////////
  // Read decode
  //////////////////////////////
  always_comb begin
    bus.hit = 1'b1;
    case (bus.raddr)
      csr_arch_pkg::CSR_MSTATUS:   bus.rdata = mstatus_q;
      csr_arch_pkg::CSR_MISA:      bus.rdata = csr_cfg_pkg::MISA_VAL;
      csr_arch_pkg::CSR_MIE:       bus.rdata = mie_q;
      csr_arch_pkg::CSR_MTVEC:     bus.rdata = mtvec_q;
      csr_arch_pkg::CSR_MSCRATCH:  bus.rdata = mscratch_q;
      csr_arch_pkg::CSR_MEPC:      bus.rdata = mepc_q;
      csr_arch_pkg::CSR_MCAUSE:    bus.rdata = mcause_q;
      csr_arch_pkg::CSR_MIP:       bus.rdata = mip_i & csr_arch_pkg::IRQ_MASK;
      csr_arch_pkg::CSR_MHARTID:   bus.rdata = hart_id_i;
      csr_arch_pkg::CSR_MVENDORID: bus.rdata = csr_cfg_pkg::MVENDORID_VAL;
      csr_arch_pkg::CSR_MARCHID:   bus.rdata = csr_cfg_pkg::MARCHID_VAL;
      csr_arch_pkg::CSR_MIMPID,
      csr_arch_pkg::CSR_MTVAL:     bus.rdata = 32'h0; // Present but hardwired
      default: begin
        bus.rdata = 32'h0;
        bus.hit   = 1'b0;        // Counter bank or unknown
      end
    endcase
  end

  assign mie_o          = mie_q;
  assign mepc_o         = mepc_q;
  assign mtvec_addr_o   = mtvec_q.addr;
  assign mtvec_mode_o   = mtvec_q.mode;
  assign m_irq_enable_o = mstatus_q.mie;

endmodule

/* hdl/csr_hpm_counter.sv */
`timescale 1ns/1ns

module csr_hpm_counter (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wr_lo_i,  // Write bits 31:0
  input  logic                                  wr_hi_i,  // Write upper half
  input  logic                                  inc_i,    // Event seen and not inhibited
  input  logic [31:0]                           wdata_i,
  output logic [csr_cfg_pkg::MHPMCOUNTER_WIDTH-1:0] count_o
);

  localparam int W = csr_cfg_pkg::MHPMCOUNTER_WIDTH;

  logic [W-1:0] count_q;

  // Software write replaces the increment of that cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (wr_lo_i) begin
      count_q[31:0] <= wdata_i;        // Upper half holds
    end else if (wr_hi_i) begin
      count_q[W-1:32] <= wdata_i;      // Lower half holds
    end else if (inc_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

/* hdl/csr_hpm_counters.sv */
`timescale 1ns/1ns

module csr_hpm_counters #(
  parameter int NUM_MHPMCOUNTERS = 1
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  csr_bus_if.bank                                bus,
  input  logic [csr_cfg_pkg::HPM_EXT_EVENTS-1:0] hpm_events_i
);

  localparam int W     = csr_cfg_pkg::MHPMCOUNTER_WIDTH;
  localparam int NEV   = csr_cfg_pkg::NUM_HPM_EVENTS;
  localparam int FIRST = csr_cfg_pkg::FIRST_HPM_IDX;

  // Address segments, bits 11:5
  localparam logic [6:0] SEG_LO  = 7'(csr_arch_pkg::CSR_MCYCLE >> 5);
  localparam logic [6:0] SEG_HI  = 7'(csr_arch_pkg::CSR_MCYCLEH >> 5);
  localparam logic [6:0] SEG_ULO = 7'(csr_arch_pkg::CSR_CYCLE >> 5);
  localparam logic [6:0] SEG_UHI = 7'(csr_arch_pkg::CSR_CYCLEH >> 5);
  localparam logic [6:0] SEG_EVT = 7'(csr_arch_pkg::CSR_MCOUNTINHIBIT >> 5);

  logic [NEV-1:0]           events;
  logic [31:0][W-1:0]       cnt;
  logic [31:0][NEV-1:0]     evt_q;
  logic [31:0]              inhibit_q;
  logic                     sel_lo, sel_hi, sel_evt, sel_inh;
  logic [4:0]               ridx;

  assign events[csr_cfg_pkg::HPM_CYCLE] = 1'b1;
  assign events[NEV-1:1]                = hpm_events_i;

  // Write decode, index follows in waddr[4:0]
  assign sel_lo  = bus.we && (bus.waddr[11:5] == SEG_LO);
  assign sel_hi  = bus.we && (bus.waddr[11:5] == SEG_HI);
  assign sel_evt = bus.we && (bus.waddr[11:5] == SEG_EVT);
  assign sel_inh = bus.we && (bus.waddr == csr_arch_pkg::CSR_MCOUNTINHIBIT);

  //////////////////////////////
  // Per-index counters
  //////////////////////////////
  for (genvar i = 0; i < 32; i++) begin : g_idx
    if ((i == 0) || (i == 2) || ((i >= FIRST) && (i < FIRST + NUM_MHPMCOUNTERS))) begin : g_on
      logic inh_q;
      logic [NEV-1:0] sel_q;
      logic inc;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) inh_q <= 1'b1;                // Counters frozen out of reset
        else if (sel_inh) inh_q <= bus.wdata[i];
      end
      assign inhibit_q[i] = inh_q;

      if (i >= FIRST) begin : g_evt
        always_ff @(posedge clk or negedge rst_n) begin
          if (!rst_n) sel_q <= '0;
          else if (sel_evt && (bus.waddr[4:0] == 5'(i))) sel_q <= bus.wdata[NEV-1:0];
        end
        assign inc = !inh_q && |(events & sel_q); // Any selected event
      end else begin : g_fixed
        assign sel_q = '0;
        assign inc   = !inh_q && ((i == 0) ? events[csr_cfg_pkg::HPM_CYCLE]
                                           : events[csr_cfg_pkg::HPM_INSTRET]);
      end
      assign evt_q[i] = sel_q;

      csr_hpm_counter u_cnt (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_lo_i (sel_lo && (bus.waddr[4:0] == 5'(i))),
        .wr_hi_i (sel_hi && (bus.waddr[4:0] == 5'(i))),
        .inc_i   (inc),
        .wdata_i (bus.wdata),
        .count_o (cnt[i])
      );
    end else begin : g_off
      assign cnt[i]       = '0;   // Unimplemented, reads zero
      assign evt_q[i]     = '0;
      assign inhibit_q[i] = 1'b0;
    end
  end

  //////////////////////////////
  // Read decode
  //////////////////////////////
  assign ridx = bus.raddr[4:0];

  always_comb begin
    bus.hit   = 1'b1;
    bus.rdata = 32'h0;
    case (bus.raddr[11:5])
      SEG_LO, SEG_ULO: bus.rdata = cnt[ridx][31:0];   // User shadow mirrors machine
      SEG_HI, SEG_UHI: bus.rdata = cnt[ridx][W-1:32];
      SEG_EVT:         bus.rdata = (ridx == 5'd0) ? inhibit_q : 32'(evt_q[ridx]);
      default:         bus.hit   = 1'b0;
    endcase
  end

endmodule

/* hdl/csr_regs_top.sv */
`timescale 1ns/1ns

module csr_regs_top #(
  parameter int NUM_MHPMCOUNTERS = 1     // 0 to 29
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [31:0]                            hart_id_i,
  // Execute read
  input  logic                                   rd_en_i,
  input  logic [11:0]                            rd_addr_i,
  input  csr_arch_pkg::csr_op_e                  rd_op_i,
  // Writeback write
  input  logic                                   wr_en_i,
  input  csr_arch_pkg::csr_op_e                  wr_op_i,
  input  logic [11:0]                            wr_addr_i,
  input  logic [31:0]                            wr_operand_i,
  input  logic [31:0]                            wr_old_i,
  // Trap control
  input  logic                                   trap_save_i,
  input  logic [5:0]                             trap_cause_i,
  input  logic [31:0]                            trap_pc_i,
  input  logic                                   mret_i,
  input  logic [31:0]                            mip_i,
  input  logic [csr_cfg_pkg::HPM_EXT_EVENTS-1:0] hpm_events_i,
  output logic [31:0]                            rdata_o,
  output logic                                   illegal_o,
  output logic [31:0]                            mie_o,
  output logic [31:0]                            mepc_o,
  output logic [23:0]                            mtvec_addr_o,
  output logic [1:0]                             mtvec_mode_o,
  output logic                                   m_irq_enable_o
);

  csr_bus_if m_bus ();  // Machine trap bank
  csr_bus_if c_bus ();  // Counter bank

  csr_access u_access (
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .rd_op_i      (rd_op_i),
    .wr_en_i      (wr_en_i),
    .wr_op_i      (wr_op_i),
    .wr_addr_i    (wr_addr_i),
    .wr_operand_i (wr_operand_i),
    .wr_old_i     (wr_old_i),
    .rdata_o      (rdata_o),
    .illegal_o    (illegal_o),
    .mbus         (m_bus),
    .cbus         (c_bus)
  );

  csr_machine_regs u_machine (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus            (m_bus),
    .hart_id_i      (hart_id_i),
    .mip_i          (mip_i),
    .trap_save_i    (trap_save_i),
    .trap_cause_i   (trap_cause_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .mie_o          (mie_o),
    .mepc_o         (mepc_o),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  csr_hpm_counters #(
    .NUM_MHPMCOUNTERS (NUM_MHPMCOUNTERS)
  ) u_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (c_bus),
    .hpm_events_i (hpm_events_i)
  );

endmodule

/* include/csr_tb_ref.svh */
`ifndef CSR_TB_REF_SVH
`define CSR_TB_REF_SVH

// 32-bit LCG with the numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Stored value of a machine CSR after one writeback op
function automatic logic [31:0] stored_value(input logic [11:0]           addr,
                                             input csr_arch_pkg::csr_op_e op,
                                             input logic [31:0]           operand,
                                             input logic [31:0]           old);
  logic [31:0] d;
  logic [31:0] res;
  case (op)
    csr_arch_pkg::CSR_OP_WRITE: d = operand;
    csr_arch_pkg::CSR_OP_SET:   d = old | operand;
    csr_arch_pkg::CSR_OP_CLEAR: d = old & ~operand;
    default:                    d = old;         // Read leaves the register alone
  endcase
  case (addr)
    csr_arch_pkg::CSR_MIE:     res = d & csr_arch_pkg::IRQ_MASK;
    csr_arch_pkg::CSR_MTVEC:   res = {d[31:8], 7'b0, d[0]};  // Base plus mode bit 0
    csr_arch_pkg::CSR_MEPC:    res = {d[31:1], 1'b0};
    csr_arch_pkg::CSR_MCAUSE:  res = {d[31], 26'b0, d[4:0]};
    csr_arch_pkg::CSR_MSTATUS: res = {19'b0, csr_arch_pkg::PRIV_M, 3'b0, d[7], 3'b0, d[3], 3'b0};
    default:                   res = d;          // mscratch keeps every bit
  endcase
  if (op == csr_arch_pkg::CSR_OP_READ) res = old;
  return res;
endfunction

// Trap entry saves mie into mpie and clears mie
function automatic logic [31:0] trap_entry_mstatus(input logic [31:0] old);
  logic [31:0] s;
  s = old;
  s[csr_arch_pkg::MSTATUS_MPIE_BIT] = old[csr_arch_pkg::MSTATUS_MIE_BIT];
  s[csr_arch_pkg::MSTATUS_MIE_BIT]  = 1'b0;
  return s;
endfunction

function automatic logic [31:0] mret_mstatus(input logic [31:0] old);
  logic [31:0] s;
  s = old;
  s[csr_arch_pkg::MSTATUS_MIE_BIT]  = old[csr_arch_pkg::MSTATUS_MPIE_BIT];
  s[csr_arch_pkg::MSTATUS_MPIE_BIT] = 1'b1;
  return s;
endfunction

function automatic logic [31:0] cause_word(input logic [5:0] cause);
  return {cause[5], 26'b0, cause[4:0]}; // Bit 5 of the cause is the interrupt flag
endfunction

// mcycle, minstret and the programmable counters
function automatic logic [31:0] inhibit_reset_mask(input int n);
  logic [31:0] m;
  m = 32'h0000_0005;
  for (int i = 0; i < n; i++) begin
    m[csr_cfg_pkg::FIRST_HPM_IDX + i] = 1'b1;
  end
  return m;
endfunction

`endif

/* bench/csr_tb.sv */
`timescale 1ns/1ns

module csr_tb;

  localparam int NUM_HPM    = 1;
  localparam int RAND_OPS   = 200;
  localparam int EV_CYCLES  = 40;
  localparam int MAX_CYCLES = 2 * (RAND_OPS * 2 + 1600); // Random ops take 2 cycles each

  // Comparison kinds
  localparam int CHK_RDATA   = 0;
  localparam int CHK_ILLEGAL = 1;
  localparam int CHK_IRQ     = 2;
  localparam int CHK_DELTA   = 3; // rdata minus the previous captured read
  localparam int CHK_CAPTURE = 4; // Only records rdata
  localparam int CHK_MIE     = 5;
  localparam int CHK_MEPC    = 6;
  localparam int CHK_MTVEC   = 7; // Base and mode packed as in the register
  localparam int EV_INSTRET  = 0; // hpm_events_i bit is the event index minus one
  localparam int EV_LOAD     = 1;

  logic clk, rst_n;
  logic [31:0] hart_id, wr_operand, wr_old, trap_pc, mip;
  logic rd_en, wr_en, trap_save, mret;
  logic [11:0] rd_addr, wr_addr;
  logic [5:0] trap_cause;
  csr_arch_pkg::csr_op_e rd_op, wr_op;
  logic [csr_cfg_pkg::HPM_EXT_EVENTS-1:0] hpm_events;
  logic [31:0] rdata, mie, mepc;
  logic [23:0] mtvec_addr;
  logic [1:0] mtvec_mode;
  logic illegal, m_irq_enable;

  logic        chk_en;
  int          chk_kind;
  logic [31:0] chk_exp, actual, expected, prev_rdata;
  string       test_name;
  int          test_errs, total_errs, n_checks, n_tests;
  int          cycles = 0;
  logic [31:0] seed;

  `include "csr_tb_ref.svh"

  csr_regs_top #(.NUM_MHPMCOUNTERS(NUM_HPM)) csr_regs_top_inst (
    .clk(clk), .rst_n(rst_n), .hart_id_i(hart_id),
    .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_op_i(rd_op),
    .wr_en_i(wr_en), .wr_op_i(wr_op), .wr_addr_i(wr_addr),
    .wr_operand_i(wr_operand), .wr_old_i(wr_old),
    .trap_save_i(trap_save), .trap_cause_i(trap_cause), .trap_pc_i(trap_pc),
    .mret_i(mret), .mip_i(mip), .hpm_events_i(hpm_events),
    .rdata_o(rdata), .illegal_o(illegal), .mie_o(mie), .mepc_o(mepc),
    .mtvec_addr_o(mtvec_addr), .mtvec_mode_o(mtvec_mode), .m_irq_enable_o(m_irq_enable)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Comparison at mid cycle where outputs have settled
  //////////////////////////////
  always @(negedge clk) begin
    if (chk_en) begin
      case (chk_kind)
        CHK_ILLEGAL: actual = {31'b0, illegal};
        CHK_IRQ:     actual = {31'b0, m_irq_enable};
        CHK_MIE:     actual = mie;
        CHK_MEPC:    actual = mepc;
        CHK_MTVEC:   actual = {mtvec_addr, 6'b0, mtvec_mode};
        default:     actual = rdata;
      endcase
      expected = (chk_kind == CHK_DELTA) ? prev_rdata + chk_exp : chk_exp;
      if (chk_kind == CHK_DELTA || chk_kind == CHK_CAPTURE) prev_rdata = rdata;
      if (chk_kind != CHK_CAPTURE) begin
        n_checks++;
        if (actual !== expected) begin
          test_errs++;
          $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
        end
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_cycle(input int kind, input logic [31:0] exp);
    chk_en   = 1'b1;
    chk_kind = kind;
    chk_exp  = exp;
    step();
    chk_en   = 1'b0;
  endtask

  task automatic read_expect(input logic [11:0] addr, input csr_arch_pkg::csr_op_e op,
                             input int kind, input logic [31:0] exp);
    rd_en   = 1'b1;
    rd_addr = addr;
    rd_op   = op;
    expect_cycle(kind, exp);
    rd_en   = 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] addr, input csr_arch_pkg::csr_op_e op,
                           input logic [31:0] operand, input logic [31:0] old);
    wr_en      = 1'b1;
    wr_addr    = addr;
    wr_op      = op;
    wr_operand = operand;
    wr_old     = old;   // Execute stage value for set and clear
    step();
    wr_en      = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic report_test();
    if (test_errs == 0) $display("Test %s: ok", test_name);
    else $display("Test %s: %0d errors", test_name, test_errs);
    total_errs += test_errs;
    n_tests++;
  endtask

  initial begin
    logic [11:0] model_addr [5];
    logic [31:0] model_val [5];
    logic [31:0] status, pc;
    logic [5:0]  cause;
    csr_arch_pkg::csr_op_e op;
    int idx, gap, n_instret, n_load;

    clk = 1'b0;
    rst_n = 1'b0;
    chk_en = 1'b0;
    rd_en = 1'b0;
    rd_addr = '0;
    rd_op = csr_arch_pkg::CSR_OP_READ;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_op = csr_arch_pkg::CSR_OP_READ;
    wr_operand = '0;
    wr_old = '0;
    trap_save = 1'b0;
    trap_cause = '0;
    trap_pc = '0;
    mret = 1'b0;
    mip = '0;
    hpm_events = '0;
    test_errs = 0;
    total_errs = 0;
    n_checks = 0;
    n_tests = 0;
    prev_rdata = '0;
    seed = lcg_next(32'd61974);
    hart_id = seed;
    model_addr = '{csr_arch_pkg::CSR_MSCRATCH, csr_arch_pkg::CSR_MIE, csr_arch_pkg::CSR_MTVEC,
                   csr_arch_pkg::CSR_MEPC, csr_arch_pkg::CSR_MSTATUS};
    model_val  = '{32'h0, 32'h0, csr_arch_pkg::MTVEC_RESET_VAL, 32'h0,
                   csr_arch_pkg::MSTATUS_RESET_VAL};
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    start_test("reset");
    read_expect(csr_arch_pkg::CSR_MSTATUS, csr_arch_pkg::CSR_OP_READ, CHK_RDATA,
                csr_arch_pkg::MSTATUS_RESET_VAL);
    read_expect(csr_arch_pkg::CSR_MTVEC, csr_arch_pkg::CSR_OP_READ, CHK_RDATA,
                csr_arch_pkg::MTVEC_RESET_VAL);
    read_expect(csr_arch_pkg::CSR_MCOUNTINHIBIT, csr_arch_pkg::CSR_OP_READ, CHK_RDATA,
                inhibit_reset_mask(NUM_HPM));
    expect_cycle(CHK_IRQ, 32'h0);
    repeat (20) step();
    read_expect(csr_arch_pkg::CSR_MCYCLE, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, 32'h0);
    report_test();

    start_test("random_ops");
    for (int i = 0; i < RAND_OPS; i++) begin
      seed = lcg_next(seed);
      idx  = (seed >> 16) % 5;
      op   = csr_arch_pkg::csr_op_e'(seed[31:30]);
      seed = lcg_next(seed);
      csr_write(model_addr[idx], op, seed, model_val[idx]);
      model_val[idx] = stored_value(model_addr[idx], op, seed, model_val[idx]);
      read_expect(model_addr[idx], csr_arch_pkg::CSR_OP_READ, CHK_RDATA, model_val[idx]);
    end
    // Direct outputs to the core follow the stored registers
    expect_cycle(CHK_MIE, model_val[1]);
    expect_cycle(CHK_MTVEC, model_val[2]);
    expect_cycle(CHK_MEPC, model_val[3]);
    report_test();

    start_test("trap_mret");
    status = stored_value(csr_arch_pkg::CSR_MSTATUS, csr_arch_pkg::CSR_OP_WRITE,
                          32'h8, 32'h0);
    csr_write(csr_arch_pkg::CSR_MSTATUS, csr_arch_pkg::CSR_OP_WRITE, 32'h8, 32'h0);
    expect_cycle(CHK_IRQ, 32'h1);
    seed = lcg_next(seed);
    cause = seed[21:16];
    seed = lcg_next(seed);
    pc = seed;
    trap_save = 1'b1;
    trap_cause = cause;
    trap_pc = pc;
    csr_write(csr_arch_pkg::CSR_MEPC, csr_arch_pkg::CSR_OP_WRITE, ~pc, 32'h0); // Trap wins
    trap_save = 1'b0;
    status = trap_entry_mstatus(status);
    read_expect(csr_arch_pkg::CSR_MEPC, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, pc);
    expect_cycle(CHK_MEPC, pc);
    read_expect(csr_arch_pkg::CSR_MCAUSE, csr_arch_pkg::CSR_OP_READ, CHK_RDATA,
                cause_word(cause));
    read_expect(csr_arch_pkg::CSR_MSTATUS, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, status);
    expect_cycle(CHK_IRQ, 32'h0);
    mret = 1'b1;
    step();
    mret = 1'b0;
    status = mret_mstatus(status);
    read_expect(csr_arch_pkg::CSR_MSTATUS, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, status);
    expect_cycle(CHK_IRQ, {31'b0, status[csr_arch_pkg::MSTATUS_MIE_BIT]});
    report_test();

    //////////////////////////////
    // Counters
    //////////////////////////////
    start_test("counters");
    csr_write(csr_arch_pkg::CSR_MCOUNTINHIBIT, csr_arch_pkg::CSR_OP_WRITE, 32'h0, 32'h0);
    csr_write(csr_arch_pkg::CSR_MHPMEVENT3, csr_arch_pkg::CSR_OP_WRITE,
              32'(1 << csr_cfg_pkg::HPM_LOAD), 32'h0);
    n_instret = 0;
    n_load = 0;
    for (int i = 0; i < EV_CYCLES; i++) begin
      seed = lcg_next(seed);
      hpm_events = seed[22:16];          // Counted at the next edge
      if (hpm_events[EV_INSTRET]) n_instret++;
      if (hpm_events[EV_LOAD]) n_load++;
      step();
    end
    hpm_events = '0;
    read_expect(csr_arch_pkg::CSR_MINSTRET, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, n_instret);
    read_expect(csr_arch_pkg::CSR_MHPMCOUNTER3, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, n_load);
    seed = lcg_next(seed);
    gap = 10 + (seed >> 16) % 64;
    read_expect(csr_arch_pkg::CSR_MCYCLE, csr_arch_pkg::CSR_OP_READ, CHK_CAPTURE, 32'h0);
    repeat (gap - 1) step();
    read_expect(csr_arch_pkg::CSR_MCYCLE, csr_arch_pkg::CSR_OP_READ, CHK_DELTA, gap);
    read_expect(csr_arch_pkg::CSR_CYCLE, csr_arch_pkg::CSR_OP_READ, CHK_CAPTURE, 32'h0);
    read_expect(csr_arch_pkg::CSR_MCYCLE, csr_arch_pkg::CSR_OP_READ, CHK_DELTA, 32'h1);
    seed = lcg_next(seed);
    csr_write(csr_arch_pkg::CSR_MCYCLEH, csr_arch_pkg::CSR_OP_WRITE, seed, 32'h0);
    read_expect(csr_arch_pkg::CSR_MCYCLEH, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, seed);
    read_expect(csr_arch_pkg::CSR_CYCLEH, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, seed);
    report_test();

    start_test("illegal");
    read_expect(12'h7C0, csr_arch_pkg::CSR_OP_READ, CHK_ILLEGAL, 32'h1);  // Nothing mapped
    read_expect(csr_arch_pkg::CSR_MHARTID, csr_arch_pkg::CSR_OP_WRITE, CHK_ILLEGAL, 32'h1);
    read_expect(csr_arch_pkg::CSR_CYCLE, csr_arch_pkg::CSR_OP_SET, CHK_ILLEGAL, 32'h1);
    read_expect(csr_arch_pkg::CSR_MHARTID, csr_arch_pkg::CSR_OP_READ, CHK_ILLEGAL, 32'h0);
    read_expect(csr_arch_pkg::CSR_MHARTID, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, hart_id);
    read_expect(12'hB0A, csr_arch_pkg::CSR_OP_READ, CHK_ILLEGAL, 32'h0);  // mhpmcounter10
    read_expect(12'hB0A, csr_arch_pkg::CSR_OP_READ, CHK_RDATA, 32'h0);
    report_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, total_errs);
    if (total_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* csr_regs.f */
+incdir+include
hdl/csr_arch_pkg.sv
hdl/csr_cfg_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access.sv
hdl/csr_machine_regs.sv
hdl/csr_hpm_counter.sv
hdl/csr_hpm_counters.sv
hdl/csr_regs_top.sv
bench/csr_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module csr_tb -f csr_regs.f -o csr_sim

./obj_dir/csr_sim > sim.log
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
